/* design/decodePkg.sv */
// Shared types for the instruction decode stage.
// Holds the 40-bit instruction layout, the opcode and flow-kind encodings
// and the packed records that travel between fetch, the two decoders,
// the merge block and the output stage.
// Modules take these definitions with a wildcard import in their header.

package decodePkg;

	// ==================================================
	// Basic scalar types
	// ==================================================

	// Register number, 64 architectural registers
	typedef logic [5:0] regNum_t;

	// Byte address used for the program counter and branch targets
	typedef logic [31:0] pcAddr_t;

	// ==================================================
	// Instruction format and opcodes
	// ==================================================

	// Opcode values understood by the decoder
	// Anything not listed here behaves like a NOP and writes nothing
	typedef enum logic [6:0] {
		OP_SYS   = 7'h00,
		OP_ADD   = 7'h02,
		OP_ADDI  = 7'h04,
		OP_LOAD  = 7'h10,
		OP_STORE = 7'h11,
		OP_JSR   = 7'h20,
		OP_DBRA  = 7'h21,
		OP_Bcc   = 7'h22,
		OP_BSR   = 7'h23,
		OP_RTD   = 7'h24,
		OP_NOP   = 7'h3F
	} opcode_e;

	// One 40-bit instruction, opcode in the low bits and imm at the top
	// The opcode is kept as raw bits so that undefined values survive intact
	typedef struct packed {
		logic [14:0] imm;
		regNum_t     rb;
		regNum_t     ra;
		regNum_t     rt;
		logic [6:0]  opcode;
	} instruction_t;

	// What fetch delivers each cycle, 72 bits in total
	typedef struct packed {
		pcAddr_t      pc;
		instruction_t instr;
	} fetchPacket_t;

	// ==================================================
	// Decoder results
	// ==================================================

	// Classes of flow-control instruction
	typedef enum logic [2:0] {
		FK_NONE = 3'd0,
		// Conditional branch
		FK_COND = 3'd1,
		// Decrement and branch
		FK_DBRA = 3'd2,
		// BSR and JSR both save a return address
		FK_CALL = 3'd3,
		FK_RET  = 3'd4,
		FK_SYS  = 3'd5
	} flowKind_e;

	// Output of the flow-control decoder
	typedef struct packed {
		logic      isFlowCtrl;
		flowKind_e kind;
		// Target is pc plus the immediate
		logic      pcRelative;
	} flowInfo_t;

	// Output of the operand decoder
	typedef struct packed {
		regNum_t     ra;
		logic        useRa;
		regNum_t     rb;
		logic        useRb;
		regNum_t     rtDefault;
		logic        writesRt;
		logic [63:0] imm64;
	} operandInfo_t;

	// Full decoded record handed to the next pipeline stage
	typedef struct packed {
		pcAddr_t     pc;
		logic [6:0]  opcode;
		flowInfo_t   flow;
		regNum_t     ra;
		logic        useRa;
		regNum_t     rb;
		logic        useRb;
		regNum_t     rt;
		logic        writesRt;
		logic [63:0] imm64;
		pcAddr_t     target;
		logic        targetValid;
	} decoded_t;

endpackage

/* design/pipeStage.sv */
// One-entry pipeline register with a valid/ready handshake.
// The payload type is a parameter so the same stage buffers fetch packets
// on the way in and decoded records on the way out.
// Upstream ready is combinational: the stage accepts when it is empty or
// when its current item leaves in the same cycle.

`timescale 1ns/1ps

module pipeStage #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     inValid,
	output logic     inReady,
	input  payload_t inData,
	output logic     outValid,
	input  logic     outReady,
	output payload_t outData
);

	// Set while the stage holds an item
	logic full;
	// Buffered payload, only meaningful while full is set
	payload_t data;

	// Room exists if empty, or if the held item is taken this cycle
	assign inReady  = !full || outReady;
	assign outValid = full;
	assign outData  = data;

	// Valid bit follows the input whenever the stage can move
	// An item leaving with nothing behind it clears the bit
	always_ff @(posedge clk)
	begin
		if (!rstN)
			full <= 1'b0;
		else if (inReady)
			full <= inValid;
	end

	// Payload loads on every accepted transfer
	always_ff @(posedge clk)
	begin
		if (inReady && inValid)
			data <= inData;
	end

endmodule

/* design/flowCtrlDecode.sv */
// Flow-control half of the decode stage.
// Flags jumps, branches, calls, returns and system calls and tells them
// apart, so later stages can steer the return stack and the branch unit.
// Purely combinational, it runs in parallel with the operand decoder.

`timescale 1ns/1ps

module flowCtrlDecode import decodePkg::*; (
	input  instruction_t instr,
	output flowInfo_t    flow
);

	// Classify one instruction by its opcode alone
	function automatic flowInfo_t fnClassify(input instruction_t ir);
		flowInfo_t fi;
		fi.isFlowCtrl = 1'b0;
		fi.kind       = FK_NONE;
		fi.pcRelative = 1'b0;
		case (ir.opcode)
		OP_SYS:
			begin
				fi.isFlowCtrl = 1'b1;
				fi.kind       = FK_SYS;
			end
		// Register-indirect call, target comes from ra at execute
		OP_JSR:
			begin
				fi.isFlowCtrl = 1'b1;
				fi.kind       = FK_CALL;
			end
		OP_DBRA:
			begin
				fi.isFlowCtrl = 1'b1;
				fi.kind       = FK_DBRA;
				fi.pcRelative = 1'b1;
			end
		OP_Bcc:
			begin
				fi.isFlowCtrl = 1'b1;
				fi.kind       = FK_COND;
				fi.pcRelative = 1'b1;
			end
		// Subroutine call with a pc-relative displacement
		OP_BSR:
			begin
				fi.isFlowCtrl = 1'b1;
				fi.kind       = FK_CALL;
				fi.pcRelative = 1'b1;
			end
		// Return, address is taken from a register
		OP_RTD:
			begin
				fi.isFlowCtrl = 1'b1;
				fi.kind       = FK_RET;
			end
		default:
			fi.isFlowCtrl = 1'b0;
		endcase
		return fi;
	endfunction

	assign flow = fnClassify(instr);

endmodule

/* design/operandDecode.sv */
// Operand half of the decode stage.
// Pulls out the register fields, says which sources are read, picks the
// default destination for ordinary operations and sign-extends the
// immediate to the full 64-bit data width.
// Flow-control destinations are not settled here, the merge block does that.

`timescale 1ns/1ps

module operandDecode import decodePkg::*; (
	input  instruction_t instr,
	output operandInfo_t ops
);

	always_comb
	begin
		// ==================================================
		// Field extraction
		// ==================================================

		// Register fields are passed on as they are, use flags say if they matter
		ops.ra        = instr.ra;
		ops.rb        = instr.rb;
		ops.rtDefault = instr.rt;

		// Copy the sign bit of the 15-bit immediate into the upper 49 bits
		ops.imm64 = {{49{instr.imm[14]}}, instr.imm};

		// ==================================================
		// Source and destination use
		// ==================================================

		ops.useRa    = 1'b0;
		ops.useRb    = 1'b0;
		ops.writesRt = 1'b0;
		case (instr.opcode)
		// Register-register arithmetic
		OP_ADD:
			begin
				ops.useRa    = 1'b1;
				ops.useRb    = 1'b1;
				ops.writesRt = 1'b1;
			end
		OP_ADDI:
			begin
				ops.useRa    = 1'b1;
				ops.writesRt = 1'b1;
			end
		// Address is ra plus imm
		OP_LOAD:
			begin
				ops.useRa    = 1'b1;
				ops.writesRt = 1'b1;
			end
		// Address from ra, store data from rb
		OP_STORE:
			begin
				ops.useRa = 1'b1;
				ops.useRb = 1'b1;
			end
		// Bcc compares ra against rb
		OP_Bcc:
			begin
				ops.useRa = 1'b1;
				ops.useRb = 1'b1;
			end
		// JSR jumps through ra, DBRA counts in ra, RTD returns through ra
		OP_JSR, OP_DBRA, OP_RTD:
			ops.useRa = 1'b1;
		// BSR, SYS, NOP and undefined opcodes read and write nothing here
		default:
			ops.useRa = 1'b0;
		endcase
	end

endmodule

/* design/decodeMerge.sv */
// Merge block of the decode stage.
// Joins the flow-control and operand results with the fetch packet into
// one decoded record. Calls and DBRA get their destination from the flow
// kind, other flow instructions write nothing, and pc-relative branches
// get their target address computed here.

`timescale 1ns/1ps

module decodeMerge import decodePkg::*; #(
	// Register that receives the return address of a call
	parameter regNum_t LinkReg = 6'd1
) (
	input  fetchPacket_t pkt,
	input  flowInfo_t    flow,
	input  operandInfo_t ops,
	output decoded_t     dec
);

	always_comb
	begin
		// Start from the plain copy of both decoder results
		dec.pc       = pkt.pc;
		dec.opcode   = pkt.instr.opcode;
		dec.flow     = flow;
		dec.ra       = ops.ra;
		dec.useRa    = ops.useRa;
		dec.rb       = ops.rb;
		dec.useRb    = ops.useRb;
		dec.rt       = ops.rtDefault;
		dec.writesRt = ops.writesRt;
		dec.imm64    = ops.imm64;

		// Destination is decided by the flow kind alone
		case (flow.kind)
		// Return address goes to the link register
		FK_CALL:
			begin
				dec.rt       = LinkReg;
				dec.writesRt = 1'b1;
			end
		// The decremented counter is written back into ra
		FK_DBRA:
			begin
				dec.rt       = ops.ra;
				dec.writesRt = 1'b1;
			end
		FK_COND, FK_RET, FK_SYS:
			dec.writesRt = 1'b0;
		// Ordinary operation, the operand decoder already chose
		default:
			dec.writesRt = ops.writesRt;
		endcase

		// Branch target only exists for pc-relative flow
		if (flow.pcRelative)
		begin
			dec.target      = pkt.pc + ops.imm64[31:0];
			dec.targetValid = 1'b1;
		end
		else
		begin
			dec.target      = '0;
			dec.targetValid = 1'b0;
		end
	end

endmodule

/* design/decodeUnit.sv */
// Top level of the instruction decode stage.
// Fetch packets enter through an input stage, are decoded by the flow and
// operand decoders side by side, merged, and leave through an output stage.
// Both ends use a valid/ready handshake and a result appears two edges
// after its packet is accepted. Up to two instructions are in flight.

`timescale 1ns/1ps

module decodeUnit import decodePkg::*; #(
	// Link register for calls, passed to the merge block
	parameter regNum_t LinkReg = 6'd1
) (
	input  logic         clk,
	input  logic         rstN,
	input  logic         inValid,
	output logic         inReady,
	input  fetchPacket_t inPkt,
	output logic         outValid,
	input  logic         outReady,
	output decoded_t     outDec
);

	// Packet held by the input stage and its handshake to the output stage
	fetchPacket_t stgPkt;
	logic         stgValid;
	logic         stgReady;

	// Decoder results and the merged record
	flowInfo_t    flow;
	operandInfo_t ops;
	decoded_t     mergedDec;

	// ==================================================
	// Input stage and decoders
	// ==================================================

	pipeStage #(.payload_t(fetchPacket_t)) stageIn (
		.clk(clk), .rstN(rstN),
		.inValid(inValid), .inReady(inReady), .inData(inPkt),
		.outValid(stgValid), .outReady(stgReady), .outData(stgPkt)
	);

	flowCtrlDecode uFlow (.instr(stgPkt.instr), .flow(flow));

	operandDecode uOps (.instr(stgPkt.instr), .ops(ops));

	decodeMerge #(.LinkReg(LinkReg)) uMerge (
		.pkt(stgPkt), .flow(flow), .ops(ops), .dec(mergedDec)
	);

	// Decoded record is registered before it leaves the unit
	pipeStage #(.payload_t(decoded_t)) stageOut (
		.clk(clk), .rstN(rstN),
		.inValid(stgValid), .inReady(stgReady), .inData(mergedDec),
		.outValid(outValid), .outReady(outReady), .outData(outDec)
	);

endmodule

/* tests/clockGen.sv */
// Clock and reset source for the decode unit testbench.
// Makes a free-running clock with a 10 ns period and holds the
// active-low synchronous reset for a fixed number of rising edges.

`timescale 1ns/1ps

module clockGen #(
	parameter int HalfPeriod  = 5,
	parameter int ResetCycles = 10
) (
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	// Release lands just after an edge, like every other testbench input
	initial
	begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

endmodule

/* tests/decodeUnitTb.sv */
// Directed testbench for the decode unit.
// Each test is a task that drives fetch packets through the valid/ready input.
// A monitor predicts every decoded record from the opcode rules and compares
// it, field by field, with what leaves the output stage, in order.
// A cycle counter bounds the run, and the summary is printed at the end.

`timescale 1ns/1ps

module decodeUnitTb import decodePkg::*; ();

	localparam regNum_t LinkReg = 6'd1;
	// Packets sent by tests 2 to 6, which sets the cycle budget
	localparam int TotalPkts  = 24 + 6 + 14 + 51 + 200;
	localparam int CycleLimit = 4 * TotalPkts + 200;

	logic         clk;
	logic         rstN;
	logic         inValid;
	logic         inReady;
	fetchPacket_t inPkt;
	logic         outValid;
	logic         outReady;
	decoded_t     outDec;

	decoded_t expQ[$];
	decoded_t expRec;
	int       acceptCnt = 0;
	int       deliverCnt = 0;
	int       inFlight;
	int       monErrors = 0;
	int       testErrors = 0;
	int       testsRun = 0;
	int       cycleCnt = 0;

	clockGen #(.HalfPeriod(5), .ResetCycles(10)) uClk (.clk(clk), .rstN(rstN));

	decodeUnit #(.LinkReg(LinkReg)) dut (
		.clk(clk), .rstN(rstN),
		.inValid(inValid), .inReady(inReady), .inPkt(inPkt),
		.outValid(outValid), .outReady(outReady), .outDec(outDec)
	);

	// ==================================================
	// Reference model and scoreboard
	// ==================================================

	// Expected record built straight from the opcode tables of the decode rules
	function automatic decoded_t expectDecode(input fetchPacket_t p);
		decoded_t   d;
		logic [6:0] op;
		op = p.instr.opcode;
		d = '0;
		d.pc     = p.pc;
		d.opcode = op;
		d.ra     = p.instr.ra;
		d.rb     = p.instr.rb;
		d.rt     = p.instr.rt;
		d.imm64  = p.instr.imm[14] ? {~49'h0, p.instr.imm} : {49'h0, p.instr.imm};
		d.useRa    = op inside {OP_ADD, OP_ADDI, OP_LOAD, OP_STORE, OP_JSR, OP_DBRA, OP_Bcc,
			OP_RTD};
		d.useRb    = op inside {OP_ADD, OP_STORE, OP_Bcc};
		d.writesRt = op inside {OP_ADD, OP_ADDI, OP_LOAD};
		d.flow.isFlowCtrl = op inside {OP_SYS, OP_JSR, OP_DBRA, OP_Bcc, OP_BSR, OP_RTD};
		d.flow.pcRelative = op inside {OP_Bcc, OP_DBRA, OP_BSR};
		if (op == OP_Bcc)
			d.flow.kind = FK_COND;
		else if (op == OP_DBRA)
			d.flow.kind = FK_DBRA;
		else if (op == OP_BSR || op == OP_JSR)
			d.flow.kind = FK_CALL;
		else if (op == OP_RTD)
			d.flow.kind = FK_RET;
		else if (op == OP_SYS)
			d.flow.kind = FK_SYS;
		// Calls link, DBRA writes its counter back, other flow writes nothing
		if (d.flow.kind == FK_CALL)
		begin
			d.rt       = LinkReg;
			d.writesRt = 1'b1;
		end
		else if (d.flow.kind == FK_DBRA)
		begin
			d.rt       = p.instr.ra;
			d.writesRt = 1'b1;
		end
		else if (d.flow.isFlowCtrl)
			d.writesRt = 1'b0;
		if (d.flow.pcRelative)
		begin
			d.target      = p.pc + d.imm64[31:0];
			d.targetValid = 1'b1;
		end
		return d;
	endfunction

	task automatic compareField(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			monErrors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Handshake signals are stable at the falling edge, so a transfer seen
	// here completes at the next rising edge
	always @(negedge clk)
	begin
		if (rstN)
		begin
			inFlight = acceptCnt - deliverCnt;
			// Input side may only stall with both stages full and the output blocked
			assert (inReady || (inFlight == 2 && !outReady))
			else
			begin
				monErrors++;
				$display("inReady low at %0t while only %0d items were held", $time, inFlight);
			end
			if (inValid && inReady)
			begin
				expQ.push_back(expectDecode(inPkt));
				acceptCnt++;
			end
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					monErrors++;
					$display("output transfer at %0t with no packet outstanding", $time);
				end
				else
				begin
					expRec = expQ.pop_front();
					compareField("pc", 64'(outDec.pc), 64'(expRec.pc));
					compareField("opcode", 64'(outDec.opcode), 64'(expRec.opcode));
					compareField("flow.isFlowCtrl", 64'(outDec.flow.isFlowCtrl),
						64'(expRec.flow.isFlowCtrl));
					compareField("flow.kind", 64'(outDec.flow.kind), 64'(expRec.flow.kind));
					compareField("flow.pcRelative", 64'(outDec.flow.pcRelative),
						64'(expRec.flow.pcRelative));
					compareField("ra", 64'(outDec.ra), 64'(expRec.ra));
					compareField("useRa", 64'(outDec.useRa), 64'(expRec.useRa));
					compareField("rb", 64'(outDec.rb), 64'(expRec.rb));
					compareField("useRb", 64'(outDec.useRb), 64'(expRec.useRb));
					compareField("rt", 64'(outDec.rt), 64'(expRec.rt));
					compareField("writesRt", 64'(outDec.writesRt), 64'(expRec.writesRt));
					compareField("imm64", outDec.imm64, expRec.imm64);
					compareField("target", 64'(outDec.target), 64'(expRec.target));
					compareField("targetValid", 64'(outDec.targetValid),
						64'(expRec.targetValid));
				end
				deliverCnt++;
			end
		end
	end

	// The budget allows four cycles per packet plus reset and drain time
	always @(posedge clk)
	begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt >= CycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================

	function automatic fetchPacket_t makePacket(input logic [6:0] op, input logic [14:0] imm);
		fetchPacket_t p;
		logic [31:0]  r;
		r = $urandom;
		p.pc = $urandom;
		p.instr.opcode = op;
		p.instr.imm    = imm;
		p.instr.rt     = r[5:0];
		p.instr.ra     = r[11:6];
		p.instr.rb     = r[17:12];
		return p;
	endfunction

	// Mostly listed opcodes, with about one packet in four fully random
	function automatic logic [6:0] pickOpcode();
		logic [31:0] r;
		r = $urandom;
		if (r[1:0] == 2'd0)
			return r[14:8];
		case (r[7:4])
		4'd0: return OP_SYS;
		4'd1: return OP_ADD;
		4'd2: return OP_ADDI;
		4'd3: return OP_LOAD;
		4'd4: return OP_STORE;
		4'd5: return OP_JSR;
		4'd6: return OP_DBRA;
		4'd7: return OP_Bcc;
		4'd8: return OP_BSR;
		4'd9: return OP_RTD;
		default: return OP_NOP;
		endcase
	endfunction

	// Holds the packet until the edge that accepts it, then returns 1 ns later
	task automatic sendPacket(input fetchPacket_t p);
		inValid = 1'b1;
		inPkt   = p;
		@(negedge clk);
		while (!inReady)
			@(negedge clk);
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		@(posedge clk);
		while (expQ.size() != 0)
			@(posedge clk);
		#1;
	endtask

	function automatic int totalErrors();
		return monErrors + testErrors;
	endfunction

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		$display("test %s finished with %0d errors", name, totalErrors() - errBefore);
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic checkReset();
		int e0;
		e0 = totalErrors();
		assert (outValid === 1'b0)
		else
		begin
			testErrors++;
			$display("mismatch at %0t: outValid got %b expected 0", $time, outValid);
		end
		assert (inReady === 1'b1)
		else
		begin
			testErrors++;
			$display("mismatch at %0t: inReady got %b expected 1", $time, inReady);
		end
		reportTest("reset", e0);
	endtask

	task automatic ordinaryOps();
		logic [6:0]  ops [6] = '{OP_ADD, OP_ADDI, OP_LOAD, OP_STORE, OP_NOP, 7'h55};
		logic [31:0] r;
		int          e0;
		e0 = totalErrors();
		for (int i = 0; i < 24; i++)
		begin
			r = $urandom;
			sendPacket(makePacket(ops[i % 6], r[14:0]));
		end
		waitDrain();
		reportTest("ordinary operations", e0);
	endtask

	task automatic flowClasses();
		logic [6:0]  ops [6] = '{OP_SYS, OP_JSR, OP_DBRA, OP_Bcc, OP_BSR, OP_RTD};
		logic [31:0] r;
		int          e0;
		e0 = totalErrors();
		foreach (ops[i])
		begin
			r = $urandom;
			sendPacket(makePacket(ops[i], r[14:0]));
		end
		waitDrain();
		reportTest("flow-control classification", e0);
	endtask

	task automatic branchTargets();
		logic [6:0]  ops [3] = '{OP_Bcc, OP_DBRA, OP_BSR};
		// Small positive, small negative, most negative and most positive
		logic [14:0] imms [4] = '{15'h0010, 15'h7FF0, 15'h4000, 15'h3FFF};
		int          e0;
		e0 = totalErrors();
		foreach (ops[i])
			foreach (imms[j])
				sendPacket(makePacket(ops[i], imms[j]));
		sendPacket(makePacket(OP_JSR, 15'h0123));
		sendPacket(makePacket(OP_RTD, 15'h7ABC));
		waitDrain();
		reportTest("branch targets", e0);
	endtask

	task automatic latencyThroughput();
		int e0;
		int startCycle;
		e0 = totalErrors();
		outReady = 1'b1;
		sendPacket(makePacket(OP_ADD, 15'h0042));
		// One edge after acceptance the packet is still in the input stage
		assert (!outValid)
		else
		begin
			testErrors++;
			$display("result appeared one edge after acceptance at %0t", $time);
		end
		@(posedge clk);
		#1;
		assert (outValid)
		else
		begin
			testErrors++;
			$display("result missing two edges after acceptance at %0t", $time);
		end
		waitDrain();
		startCycle = cycleCnt;
		for (int i = 0; i < 50; i++)
			sendPacket(makePacket(pickOpcode(), 15'h1000 + 15'(i)));
		assert (cycleCnt - startCycle == 50)
		else
		begin
			testErrors++;
			$display("mismatch at %0t: cycles for 50 packets got %0d expected 50", $time,
				cycleCnt - startCycle);
		end
		waitDrain();
		reportTest("latency and throughput", e0);
	endtask

	task automatic backPressure();
		logic [31:0] r;
		logic [31:0] rdy;
		bit          done;
		int          e0;
		e0 = totalErrors();
		done = 1'b0;
		fork
			begin
				for (int i = 0; i < 200; i++)
				begin
					r = $urandom;
					sendPacket(makePacket(pickOpcode(), r[14:0]));
				end
				done = 1'b1;
			end
			begin
				while (!done)
				begin
					rdy = $urandom;
					outReady = rdy[0];
					@(posedge clk);
					#1;
				end
			end
		join
		outReady = 1'b1;
		waitDrain();
		reportTest("back-pressure", e0);
	endtask

	initial
	begin
		void'($urandom(32'hcea2_30c4));
		inValid  = 1'b0;
		inPkt    = '0;
		outReady = 1'b1;
		wait (rstN == 1'b1);
		@(posedge clk);
		#1;
		checkReset();
		ordinaryOps();
		flowClasses();
		branchTargets();
		latencyThroughput();
		backPressure();
		assert (expQ.size() == 0 && acceptCnt == deliverCnt)
		else
		begin
			testErrors++;
			$display("%0d packets accepted but %0d results delivered", acceptCnt, deliverCnt);
		end
		$display("%0d tests run, %0d results checked, %0d errors", testsRun, deliverCnt,
			totalErrors());
		if (totalErrors() == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* project.f */
design/decodePkg.sv
design/pipeStage.sv
design/flowCtrlDecode.sv
design/operandDecode.sv
design/decodeMerge.sv
design/decodeUnit.sv
tests/clockGen.sv
tests/decodeUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the decode unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module decodeUnitTb -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
